// ==== Bender.yml ====
package:
  name: mmcm_reconfig

sources:
  - hw/mmcm_cfg_pkg.sv
  - hw/mmcm_lock_filter_lut.sv
  - hw/mmcm_step_rom.sv
  - hw/mmcm_drp_sequencer.sv
  - hw/mmcm_reconfig_top.sv
  - target: test
    files:
      - tb/mmcm_drp_model.sv
      - tb/tb_mmcm_reconfig.sv

// ==== files.f ====
hw/mmcm_cfg_pkg.sv
hw/mmcm_lock_filter_lut.sv
hw/mmcm_step_rom.sv
hw/mmcm_drp_sequencer.sv
hw/mmcm_reconfig_top.sv
tb/mmcm_drp_model.sv
tb/tb_mmcm_reconfig.sv

// ==== hw/mmcm_cfg_pkg.sv ====
package mmcm_cfg_pkg;

   // DRP bus words
   typedef logic [6:0]  drp_addr_t;
   typedef logic [15:0] drp_data_t;

   // One request cycle on the DRP, den qualifies the rest
   typedef struct packed {
      drp_addr_t addr;
      drp_data_t wdata;
      logic      den;
      logic      dwe;
   } drp_req_t;

   // Output or feedback counter settings
   typedef struct packed {
      logic [2:0] phase_mux;
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic [2:0] frac;
      logic       frac_en;
      logic       wf_r;
      logic       edge_sel;
      logic       no_count;
      logic [5:0] delay_time;
   } clkout_cfg_t;

   // Input divider settings
   typedef struct packed {
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic       edge_sel;
      logic       no_count;
   } divclk_cfg_t;

   // Lock detector and loop filter words from the lookup tables
   typedef logic [39:0] lock_cfg_t;
   typedef logic [9:0]  filt_cfg_t;

   // Read-modify-write steps, in issue order
   typedef enum logic [3:0] {
      STEP_POWER      = 4'd0,
      STEP_CLKOUT0_1  = 4'd1,
      STEP_CLKOUT0_2  = 4'd2,
      STEP_DIVCLK     = 4'd3,
      STEP_CLKFBOUT_1 = 4'd4,
      STEP_CLKFBOUT_2 = 4'd5,
      STEP_LOCK_1     = 4'd6,
      STEP_LOCK_2     = 4'd7,
      STEP_LOCK_3     = 4'd8,
      STEP_FILT_1     = 4'd9,
      STEP_FILT_2     = 4'd10
   } step_t;

   localparam int unsigned NUM_STEPS = 11;

   // DRP register addresses
   localparam drp_addr_t POWER_ADDR     = 7'h28;
   localparam drp_addr_t CLKOUT0_ADDR1  = 7'h08;
   localparam drp_addr_t CLKOUT0_ADDR2  = 7'h09;
   localparam drp_addr_t DIVCLK_ADDR    = 7'h16;
   localparam drp_addr_t CLKFBOUT_ADDR1 = 7'h14;
   localparam drp_addr_t CLKFBOUT_ADDR2 = 7'h15;
   localparam drp_addr_t LOCK_ADDR1     = 7'h18;
   localparam drp_addr_t LOCK_ADDR2     = 7'h19;
   localparam drp_addr_t LOCK_ADDR3     = 7'h1A;
   localparam drp_addr_t FILT_ADDR1     = 7'h4E;
   localparam drp_addr_t FILT_ADDR2     = 7'h4F;

   // Keep-masks, a set bit preserves the value read back
   localparam drp_data_t POWER_MASK     = 16'h0000;
   localparam drp_data_t CLKOUT0_MASK1  = 16'h1000;
   localparam drp_data_t CLKOUT0_MASK2  = 16'h8000;
   localparam drp_data_t DIVCLK_MASK    = 16'hC000;
   localparam drp_data_t CLKFBOUT_MASK1 = 16'h1000;
   localparam drp_data_t CLKFBOUT_MASK2 = 16'h8000;
   localparam drp_data_t LOCK_MASK1     = 16'hFC00;
   localparam drp_data_t LOCK_MASK2     = 16'h8000;
   localparam drp_data_t LOCK_MASK3     = 16'h8000;
   localparam drp_data_t FILT_MASK1     = 16'h66FF;
   localparam drp_data_t FILT_MASK2     = 16'h666F;

endpackage

// ==== hw/mmcm_drp_sequencer.sv ====
module mmcm_drp_sequencer (
   input  logic                    dclk,
   input  logic                    rst,
   input  logic                    locked,
   input  logic                    start,
   input  logic                    drdy,
   input  mmcm_cfg_pkg::drp_data_t drp_rdata,
   input  mmcm_cfg_pkg::drp_addr_t step_addr,
   input  mmcm_cfg_pkg::drp_data_t step_mask,
   input  mmcm_cfg_pkg::drp_data_t step_bits,
   output mmcm_cfg_pkg::step_t     step,
   output mmcm_cfg_pkg::drp_req_t  drp,
   output logic                    mmcm_rst,
   output logic                    ready,
   output logic                    done
);

   typedef enum logic [3:0] {
      ST_RESTART,
      ST_WAIT_LOCK,
      ST_WAIT_START,
      ST_ADDRESS,
      ST_WAIT_READ,
      ST_MASK,
      ST_SET,
      ST_WRITE,
      ST_WAIT_WRITE
   } state_t;

   state_t                  state;
   logic [3:0]              write_cnt;
   logic                    den_q;
   logic                    dwe_q;
   mmcm_cfg_pkg::drp_addr_t addr_q;
   mmcm_cfg_pkg::drp_data_t data_word;

   assign drp = '{addr: addr_q, wdata: data_word, den: den_q, dwe: dwe_q};

   always_ff @(posedge dclk) begin
      if (rst) begin
         state     <= ST_RESTART;
         step      <= mmcm_cfg_pkg::STEP_POWER;
         write_cnt <= '0;
         den_q     <= 1'b0;
         dwe_q     <= 1'b0;
         mmcm_rst  <= 1'b0;
         ready     <= 1'b0;
         done      <= 1'b0;
      end else begin
         // Request strobes and done are single-cycle
         den_q <= 1'b0;
         dwe_q <= 1'b0;
         done  <= 1'b0;
         case (state)
            ST_RESTART: begin
               mmcm_rst <= 1'b1;
               state    <= ST_WAIT_LOCK;
            end
            ST_WAIT_LOCK: begin
               mmcm_rst <= 1'b0;
               // A lock seen while the reset pulse is still out is stale
               if (locked && !mmcm_rst) begin
                  ready <= 1'b1;
                  state <= ST_WAIT_START;
               end
            end
            ST_WAIT_START: begin
               if (start) begin
                  ready     <= 1'b0;
                  step      <= mmcm_cfg_pkg::STEP_POWER;
                  write_cnt <= '0;
                  state     <= ST_ADDRESS;
               end
            end
            ST_ADDRESS: begin
               // Block stays in reset for the whole sequence
               mmcm_rst <= 1'b1;
               den_q    <= 1'b1;
               state    <= ST_WAIT_READ;
            end
            ST_WAIT_READ: begin
               if (drdy) begin
                  state <= ST_MASK;
               end
            end
            ST_MASK: begin
               state <= ST_SET;
            end
            ST_SET: begin
               state <= ST_WRITE;
            end
            ST_WRITE: begin
               den_q <= 1'b1;
               dwe_q <= 1'b1;
               state <= ST_WAIT_WRITE;
            end
            ST_WAIT_WRITE: begin
               if (drdy) begin
                  write_cnt <= write_cnt + 4'd1;
                  if (write_cnt == 4'(mmcm_cfg_pkg::NUM_STEPS - 1)) begin
                     mmcm_rst <= 1'b0;
                     done     <= 1'b1;
                     state    <= ST_WAIT_LOCK;
                  end else begin
                     step  <= mmcm_cfg_pkg::step_t'(step + 4'd1);
                     state <= ST_ADDRESS;
                  end
               end
            end
            default: begin
               state <= ST_RESTART;
            end
         endcase
      end
   end

   // Address and read-modify-write data path
   always_ff @(posedge dclk) begin
      case (state)
         ST_ADDRESS: begin
            addr_q <= step_addr;
         end
         ST_WAIT_READ: begin
            if (drdy) begin
               data_word <= drp_rdata;
            end
         end
         ST_MASK: begin
            data_word <= data_word & step_mask;
         end
         ST_SET: begin
            data_word <= data_word | step_bits;
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== hw/mmcm_lock_filter_lut.sv ====
module mmcm_lock_filter_lut (
   input  logic                      dclk,
   input  mmcm_cfg_pkg::divclk_cfg_t divclk_cfg,
   output mmcm_cfg_pkg::lock_cfg_t   lock_word,
   output mmcm_cfg_pkg::filt_cfg_t   filt_word
);

   // Divide value minus one, wraps out of range when both times are zero
   logic [7:0] div_idx;

   assign div_idx = 8'(divclk_cfg.high_time) + 8'(divclk_cfg.low_time) - 8'd1;

   always_ff @(posedge dclk) begin
      case (div_idx) inside
         [8'd0:8'd1]:   lock_word <= 40'b00110_00110_1111101000_1111101001_0000000001;
         8'd2:          lock_word <= 40'b01000_01000_1111101000_1111101001_0000000001;
         8'd3:          lock_word <= 40'b01011_01011_1111101000_1111101001_0000000001;
         8'd4:          lock_word <= 40'b01110_01110_1111101000_1111101001_0000000001;
         8'd5:          lock_word <= 40'b10001_10001_1111101000_1111101001_0000000001;
         8'd6:          lock_word <= 40'b10011_10011_1111101000_1111101001_0000000001;
         8'd7:          lock_word <= 40'b10110_10110_1111101000_1111101001_0000000001;
         8'd8:          lock_word <= 40'b11001_11001_1111101000_1111101001_0000000001;
         8'd9:          lock_word <= 40'b11100_11100_1111101000_1111101001_0000000001;
         8'd10:         lock_word <= 40'b11111_11111_1110000100_1111101001_0000000001;
         8'd11:         lock_word <= 40'b11111_11111_1100111001_1111101001_0000000001;
         8'd12:         lock_word <= 40'b11111_11111_1011101110_1111101001_0000000001;
         8'd13:         lock_word <= 40'b11111_11111_1010111100_1111101001_0000000001;
         8'd14:         lock_word <= 40'b11111_11111_1010001010_1111101001_0000000001;
         8'd15:         lock_word <= 40'b11111_11111_1001110001_1111101001_0000000001;
         8'd16:         lock_word <= 40'b11111_11111_1000111111_1111101001_0000000001;
         8'd17:         lock_word <= 40'b11111_11111_1000100110_1111101001_0000000001;
         8'd18:         lock_word <= 40'b11111_11111_1000001101_1111101001_0000000001;
         8'd19:         lock_word <= 40'b11111_11111_0111110100_1111101001_0000000001;
         8'd20:         lock_word <= 40'b11111_11111_0111011011_1111101001_0000000001;
         8'd21:         lock_word <= 40'b11111_11111_0111000010_1111101001_0000000001;
         8'd22:         lock_word <= 40'b11111_11111_0110101001_1111101001_0000000001;
         [8'd23:8'd24]: lock_word <= 40'b11111_11111_0110010000_1111101001_0000000001;
         8'd25:         lock_word <= 40'b11111_11111_0101110111_1111101001_0000000001;
         [8'd26:8'd27]: lock_word <= 40'b11111_11111_0101011110_1111101001_0000000001;
         [8'd28:8'd29]: lock_word <= 40'b11111_11111_0101000101_1111101001_0000000001;
         [8'd30:8'd32]: lock_word <= 40'b11111_11111_0100101100_1111101001_0000000001;
         [8'd33:8'd35]: lock_word <= 40'b11111_11111_0100010011_1111101001_0000000001;
         [8'd36:8'd63]: lock_word <= 40'b11111_11111_0011111010_1111101001_0000000001;
         // Same as index 0
         default:       lock_word <= 40'b00110_00110_1111101000_1111101001_0000000001;
      endcase
   end

   always_ff @(posedge dclk) begin
      case (div_idx) inside
         8'd0:          filt_word <= 10'b0010_1111_00;
         8'd1:          filt_word <= 10'b0100_1111_00;
         8'd2:          filt_word <= 10'b0101_1011_00;
         8'd3:          filt_word <= 10'b0111_0111_00;
         8'd4:          filt_word <= 10'b1101_0111_00;
         8'd5:          filt_word <= 10'b1110_1011_00;
         8'd6:          filt_word <= 10'b1110_1101_00;
         8'd7:          filt_word <= 10'b1111_0011_00;
         8'd8:          filt_word <= 10'b1110_0101_00;
         8'd9:          filt_word <= 10'b1111_0101_00;
         8'd10:         filt_word <= 10'b1111_1001_00;
         8'd11:         filt_word <= 10'b1101_0001_00;
         [8'd12:8'd15]: filt_word <= 10'b1111_1001_00;
         [8'd16:8'd17]: filt_word <= 10'b1111_0101_00;
         [8'd18:8'd20]: filt_word <= 10'b1100_0001_00;
         [8'd21:8'd24]: filt_word <= 10'b0101_1100_00;
         [8'd25:8'd40]: filt_word <= 10'b0011_0100_00;
         [8'd41:8'd45]: filt_word <= 10'b0010_1000_00;
         [8'd46:8'd47]: filt_word <= 10'b0111_0001_00;
         [8'd48:8'd51]: filt_word <= 10'b0100_1100_00;
         [8'd52:8'd53]: filt_word <= 10'b0110_0001_00;
         [8'd54:8'd56]: filt_word <= 10'b0101_0110_00;
         [8'd57:8'd60]: filt_word <= 10'b0010_0100_00;
         8'd61:         filt_word <= 10'b0100_1010_00;
         [8'd62:8'd63]: filt_word <= 10'b0011_1100_00;
         default:       filt_word <= 10'b0010_1111_00;
      endcase
   end

endmodule

// ==== hw/mmcm_reconfig_top.sv ====
module mmcm_reconfig_top (
   input  logic                      dclk,
   input  logic                      rst,
   input  logic                      locked,
   output logic                      mmcm_rst,
   output mmcm_cfg_pkg::drp_req_t    drp,
   input  mmcm_cfg_pkg::drp_data_t   drp_rdata,
   input  logic                      drdy,
   input  mmcm_cfg_pkg::clkout_cfg_t clkout0_cfg,
   input  mmcm_cfg_pkg::clkout_cfg_t clkfbout_cfg,
   input  mmcm_cfg_pkg::divclk_cfg_t divclk_cfg,
   input  logic                      start,
   output logic                      ready,
   output logic                      done
);

   mmcm_cfg_pkg::step_t     step;
   mmcm_cfg_pkg::drp_addr_t step_addr;
   mmcm_cfg_pkg::drp_data_t step_mask;
   mmcm_cfg_pkg::drp_data_t step_bits;
   mmcm_cfg_pkg::lock_cfg_t lock_word;
   mmcm_cfg_pkg::filt_cfg_t filt_word;

   mmcm_lock_filter_lut lut_i (
      .dclk       (dclk),
      .divclk_cfg (divclk_cfg),
      .lock_word  (lock_word),
      .filt_word  (filt_word)
   );

   mmcm_step_rom rom_i (
      .step         (step),
      .clkout0_cfg  (clkout0_cfg),
      .clkfbout_cfg (clkfbout_cfg),
      .divclk_cfg   (divclk_cfg),
      .lock_word    (lock_word),
      .filt_word    (filt_word),
      .step_addr    (step_addr),
      .step_mask    (step_mask),
      .step_bits    (step_bits)
   );

   mmcm_drp_sequencer seq_i (
      .dclk      (dclk),
      .rst       (rst),
      .locked    (locked),
      .start     (start),
      .drdy      (drdy),
      .drp_rdata (drp_rdata),
      .step_addr (step_addr),
      .step_mask (step_mask),
      .step_bits (step_bits),
      .step      (step),
      .drp       (drp),
      .mmcm_rst  (mmcm_rst),
      .ready     (ready),
      .done      (done)
   );

endmodule

// ==== hw/mmcm_step_rom.sv ====
module mmcm_step_rom (
   input  mmcm_cfg_pkg::step_t       step,
   input  mmcm_cfg_pkg::clkout_cfg_t clkout0_cfg,
   input  mmcm_cfg_pkg::clkout_cfg_t clkfbout_cfg,
   input  mmcm_cfg_pkg::divclk_cfg_t divclk_cfg,
   input  mmcm_cfg_pkg::lock_cfg_t   lock_word,
   input  mmcm_cfg_pkg::filt_cfg_t   filt_word,
   output mmcm_cfg_pkg::drp_addr_t   step_addr,
   output mmcm_cfg_pkg::drp_data_t   step_mask,
   output mmcm_cfg_pkg::drp_data_t   step_bits
);

   // First counter word: phase mux, high and low time
   function automatic mmcm_cfg_pkg::drp_data_t cnt_word1(input mmcm_cfg_pkg::clkout_cfg_t c);
      return {c.phase_mux, 1'b0, c.high_time, c.low_time};
   endfunction

   // Second counter word: fractional part, edge, bypass and delay
   function automatic mmcm_cfg_pkg::drp_data_t cnt_word2(input mmcm_cfg_pkg::clkout_cfg_t c);
      return {1'b0, c.frac, c.frac_en, c.wf_r, 2'b00, c.edge_sel, c.no_count, c.delay_time};
   endfunction

   always_comb begin
      case (step)
         mmcm_cfg_pkg::STEP_POWER: begin
            step_addr = mmcm_cfg_pkg::POWER_ADDR;
            step_mask = mmcm_cfg_pkg::POWER_MASK;
            step_bits = 16'hFFFF;
         end
         mmcm_cfg_pkg::STEP_CLKOUT0_1: begin
            step_addr = mmcm_cfg_pkg::CLKOUT0_ADDR1;
            step_mask = mmcm_cfg_pkg::CLKOUT0_MASK1;
            step_bits = cnt_word1(clkout0_cfg);
         end
         mmcm_cfg_pkg::STEP_CLKOUT0_2: begin
            step_addr = mmcm_cfg_pkg::CLKOUT0_ADDR2;
            step_mask = mmcm_cfg_pkg::CLKOUT0_MASK2;
            step_bits = cnt_word2(clkout0_cfg);
         end
         mmcm_cfg_pkg::STEP_DIVCLK: begin
            step_addr = mmcm_cfg_pkg::DIVCLK_ADDR;
            step_mask = mmcm_cfg_pkg::DIVCLK_MASK;
            step_bits = {2'b00, divclk_cfg.edge_sel, divclk_cfg.no_count,
                         divclk_cfg.high_time, divclk_cfg.low_time};
         end
         mmcm_cfg_pkg::STEP_CLKFBOUT_1: begin
            step_addr = mmcm_cfg_pkg::CLKFBOUT_ADDR1;
            step_mask = mmcm_cfg_pkg::CLKFBOUT_MASK1;
            step_bits = cnt_word1(clkfbout_cfg);
         end
         mmcm_cfg_pkg::STEP_CLKFBOUT_2: begin
            step_addr = mmcm_cfg_pkg::CLKFBOUT_ADDR2;
            step_mask = mmcm_cfg_pkg::CLKFBOUT_MASK2;
            step_bits = cnt_word2(clkfbout_cfg);
         end
         // Lock word is spread over three registers
         mmcm_cfg_pkg::STEP_LOCK_1: begin
            step_addr = mmcm_cfg_pkg::LOCK_ADDR1;
            step_mask = mmcm_cfg_pkg::LOCK_MASK1;
            step_bits = {6'b000000, lock_word[29:20]};
         end
         mmcm_cfg_pkg::STEP_LOCK_2: begin
            step_addr = mmcm_cfg_pkg::LOCK_ADDR2;
            step_mask = mmcm_cfg_pkg::LOCK_MASK2;
            step_bits = {1'b0, lock_word[34:30], lock_word[9:0]};
         end
         mmcm_cfg_pkg::STEP_LOCK_3: begin
            step_addr = mmcm_cfg_pkg::LOCK_ADDR3;
            step_mask = mmcm_cfg_pkg::LOCK_MASK3;
            step_bits = {1'b0, lock_word[39:35], lock_word[19:10]};
         end
         // Filter bits sit in scattered positions
         mmcm_cfg_pkg::STEP_FILT_1: begin
            step_addr = mmcm_cfg_pkg::FILT_ADDR1;
            step_mask = mmcm_cfg_pkg::FILT_MASK1;
            step_bits = {filt_word[9], 2'b00, filt_word[8:7], 2'b00, filt_word[6], 8'h00};
         end
         mmcm_cfg_pkg::STEP_FILT_2: begin
            step_addr = mmcm_cfg_pkg::FILT_ADDR2;
            step_mask = mmcm_cfg_pkg::FILT_MASK2;
            step_bits = {filt_word[5], 2'b00, filt_word[4:3], 2'b00,
                         filt_word[2:1], 2'b00, filt_word[0], 4'h0};
         end
         default: begin
            step_addr = '0;
            step_mask = '0;
            step_bits = '0;
         end
      endcase
   end

endmodule

// ==== tb/mmcm_drp_model.sv ====
module mmcm_drp_model (
   input  logic                    dclk,
   input  mmcm_cfg_pkg::drp_req_t  drp,
   input  logic                    mmcm_rst,
   output mmcm_cfg_pkg::drp_data_t drp_rdata,
   output logic                    drdy,
   output logic                    locked
);

   mmcm_cfg_pkg::drp_data_t regs [128];
   // Contents of each address just before its last write
   mmcm_cfg_pkg::drp_data_t prior_regs [128];

   logic                    pending;
   int unsigned             delay;
   int unsigned             lock_delay;
   mmcm_cfg_pkg::drp_addr_t pend_addr;

   initial begin
      pending    = 1'b0;
      delay      = 0;
      lock_delay = 20;
      pend_addr  = '0;
      drdy       = 1'b0;
      locked     = 1'b0;
      drp_rdata  = '0;
      @(posedge dclk);
      for (int i = 0; i < 128; i++) begin
         regs[i]       = 16'($urandom);
         prior_regs[i] = '0;
      end
   end

   // One transaction at a time with drdy 1 to 4 cycles after den
   always @(negedge dclk) begin
      drdy <= 1'b0;
      if (drp.den) begin
         pending   <= 1'b1;
         pend_addr <= drp.addr;
         delay     <= $urandom_range(4, 1) - 1;
         if (drp.dwe) begin
            prior_regs[drp.addr] <= regs[drp.addr];
            regs[drp.addr]       <= drp.wdata;
         end
      end else if (pending) begin
         if (delay == 0) begin
            pending   <= 1'b0;
            drdy      <= 1'b1;
            drp_rdata <= regs[pend_addr];
         end else begin
            delay <= delay - 1;
         end
      end
   end

   // Lock drops in reset and returns 5 to 20 cycles after release
   always @(negedge dclk) begin
      if (mmcm_rst) begin
         locked     <= 1'b0;
         lock_delay <= $urandom_range(20, 5);
      end else if (!locked) begin
         if (lock_delay <= 1) begin
            locked <= 1'b1;
         end else begin
            lock_delay <= lock_delay - 1;
         end
      end
   end

endmodule

// ==== tb/tb_mmcm_reconfig.sv ====
module tb_mmcm_reconfig;

   logic                      dclk;
   logic                      rst;
   logic                      locked;
   logic                      mmcm_rst;
   logic                      drdy;
   logic                      start;
   logic                      ready;
   logic                      done;
   mmcm_cfg_pkg::drp_req_t    drp;
   mmcm_cfg_pkg::drp_data_t   drp_rdata;
   mmcm_cfg_pkg::clkout_cfg_t clkout0_cfg;
   mmcm_cfg_pkg::clkout_cfg_t clkfbout_cfg;
   mmcm_cfg_pkg::divclk_cfg_t divclk_cfg;

   // Expected register order and keep-masks
   logic [6:0]  addr_order [11] = '{7'h28, 7'h08, 7'h09, 7'h16, 7'h14, 7'h15,
                                    7'h18, 7'h19, 7'h1A, 7'h4E, 7'h4F};
   logic [15:0] mask_order [11] = '{16'h0000, 16'h1000, 16'h8000, 16'hC000, 16'h1000,
                                    16'h8000, 16'hFC00, 16'h8000, 16'h8000, 16'h66FF,
                                    16'h666F};

   // Divider settings for indices 1, 4 and 30 with their table entries
   logic [5:0]  run_high [3] = '{6'd1, 6'd2, 6'd15};
   logic [5:0]  run_low  [3] = '{6'd1, 6'd3, 6'd16};
   logic [39:0] lock_ref [3] = '{40'b00110_00110_1111101000_1111101001_0000000001,
                                 40'b01110_01110_1111101000_1111101001_0000000001,
                                 40'b11111_11111_0100101100_1111101001_0000000001};
   logic [9:0]  filt_ref [3] = '{10'b0100111100, 10'b1101011100, 10'b0011010000};

   logic [39:0] cur_lock;
   logic [9:0]  cur_filt;
   logic        outstanding;
   logic        out_write;
   logic        busy;
   logic        done_q;
   logic [6:0]  last_addr;
   logic [15:0] wr_data;
   int          rd_cnt;
   int          wr_cnt;
   int          done_cnt;

   mmcm_reconfig_top dut_i (
      .dclk         (dclk),
      .rst          (rst),
      .locked       (locked),
      .mmcm_rst     (mmcm_rst),
      .drp          (drp),
      .drp_rdata    (drp_rdata),
      .drdy         (drdy),
      .clkout0_cfg  (clkout0_cfg),
      .clkfbout_cfg (clkfbout_cfg),
      .divclk_cfg   (divclk_cfg),
      .start        (start),
      .ready        (ready),
      .done         (done)
   );

   mmcm_drp_model model_i (
      .dclk      (dclk),
      .drp       (drp),
      .mmcm_rst  (mmcm_rst),
      .drp_rdata (drp_rdata),
      .drdy      (drdy),
      .locked    (locked)
   );

   initial begin
      dclk = 1'b0;
      forever #20 dclk = ~dclk;
   end

   task automatic fail_run(input string msg);
      $display("*** FAILED ***");
      $display("%s", msg);
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      fail_run($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
   endtask

   // New bit field of each step from the configuration inputs
   function automatic logic [15:0] exp_field(input int s);
      case (s)
         0: return 16'hFFFF;
         1: return {clkout0_cfg.phase_mux, 1'b0, clkout0_cfg.high_time, clkout0_cfg.low_time};
         2: return {1'b0, clkout0_cfg.frac, clkout0_cfg.frac_en, clkout0_cfg.wf_r, 2'b00,
                    clkout0_cfg.edge_sel, clkout0_cfg.no_count, clkout0_cfg.delay_time};
         3: return {2'b00, divclk_cfg.edge_sel, divclk_cfg.no_count,
                    divclk_cfg.high_time, divclk_cfg.low_time};
         4: return {clkfbout_cfg.phase_mux, 1'b0, clkfbout_cfg.high_time,
                    clkfbout_cfg.low_time};
         5: return {1'b0, clkfbout_cfg.frac, clkfbout_cfg.frac_en, clkfbout_cfg.wf_r, 2'b00,
                    clkfbout_cfg.edge_sel, clkfbout_cfg.no_count, clkfbout_cfg.delay_time};
         6: return {6'd0, cur_lock[29:20]};
         7: return {1'b0, cur_lock[34:30], cur_lock[9:0]};
         8: return {1'b0, cur_lock[39:35], cur_lock[19:10]};
         9: return {cur_filt[9], 2'b00, cur_filt[8:7], 2'b00, cur_filt[6], 8'h00};
         10: return {cur_filt[5], 2'b00, cur_filt[4:3], 2'b00, cur_filt[2:1], 2'b00,
                     cur_filt[0], 4'h0};
         default: return 'x;
      endcase
   endfunction

   // Protocol and data checks on the rising edge
   always @(posedge dclk) begin
      if (!rst) begin
         done_q <= done;
         assert (!ready || locked) else fail_run("ready is high while locked is low");
         assert (!(ready && busy)) else fail_run("ready is high during a reconfiguration");
         // Block held in reset from the first read until done
         assert (rd_cnt == 0 || done || mmcm_rst)
         else fail_run("mmcm_rst dropped during a reconfiguration");
         if (start && ready) begin
            busy <= 1'b1;
         end
         if (drdy) begin
            assert (outstanding) else fail_run("drdy arrived with no request pending");
            outstanding <= 1'b0;
            if (out_write) begin
               assert (wr_data == ((model_i.prior_regs[last_addr] & mask_order[wr_cnt])
                                   | exp_field(wr_cnt)))
               else report_mismatch($sformatf("write_data step %0d", wr_cnt),
                                    (model_i.prior_regs[last_addr] & mask_order[wr_cnt])
                                    | exp_field(wr_cnt), wr_data);
               wr_cnt <= wr_cnt + 1;
            end
         end
         if (drp.den) begin
            assert (!outstanding) else fail_run("den rose while a transaction was pending");
            assert (mmcm_rst) else fail_run("mmcm_rst low during a DRP request");
            outstanding <= 1'b1;
            out_write   <= drp.dwe;
            if (!drp.dwe) begin
               assert (rd_cnt < 11 && rd_cnt == wr_cnt)
               else report_mismatch("read_count", wr_cnt, rd_cnt);
               assert (drp.addr == addr_order[rd_cnt])
               else report_mismatch("read_addr", addr_order[rd_cnt], drp.addr);
               rd_cnt    <= rd_cnt + 1;
               last_addr <= drp.addr;
            end else begin
               assert (wr_cnt == rd_cnt - 1)
               else report_mismatch("write_count", rd_cnt - 1, wr_cnt);
               assert (drp.addr == last_addr)
               else report_mismatch("write_addr", last_addr, drp.addr);
               wr_data <= drp.wdata;
            end
         end
         if (done) begin
            assert (!done_q) else fail_run("done held high for more than one cycle");
            assert (!mmcm_rst) else fail_run("mmcm_rst still high when done pulsed");
            assert (wr_cnt == 11) else report_mismatch("writes_per_run", 11, wr_cnt);
            rd_cnt   <= 0;
            wr_cnt   <= 0;
            busy     <= 1'b0;
            done_cnt <= done_cnt + 1;
         end
      end
   end

   task automatic wait_for_ready();
      int n;
      n = 0;
      while (!ready) begin
         @(negedge dclk);
         n++;
         if (n > 500) fail_run("timeout waiting for ready");
      end
   endtask

   task automatic wait_for_done();
      int n;
      n = 0;
      while (!done) begin
         @(negedge dclk);
         n++;
         if (n > 2000) fail_run("timeout waiting for done");
      end
   endtask

   task automatic run_reconfig(input int r);
      wait_for_ready();
      clkout0_cfg          = 28'($urandom);
      clkfbout_cfg         = 28'($urandom);
      divclk_cfg.high_time = run_high[r];
      divclk_cfg.low_time  = run_low[r];
      divclk_cfg.edge_sel  = 1'($urandom);
      divclk_cfg.no_count  = 1'($urandom);
      cur_lock             = lock_ref[r];
      cur_filt             = filt_ref[r];
      start                = 1'b1;
      @(negedge dclk);
      start = 1'b0;
      wait_for_done();
   endtask

   initial begin
      void'($urandom(7));
      rst          = 1'b1;
      start        = 1'b0;
      clkout0_cfg  = '0;
      clkfbout_cfg = '0;
      divclk_cfg   = '0;
      outstanding  = 1'b0;
      out_write    = 1'b0;
      busy         = 1'b0;
      done_q       = 1'b0;
      last_addr    = '0;
      wr_data      = '0;
      rd_cnt       = 0;
      wr_cnt       = 0;
      done_cnt     = 0;
      repeat (4) @(posedge dclk);
      @(negedge dclk);
      rst = 1'b0;
      assert (!drp.den && !drp.dwe && !ready && !done)
      else fail_run("outputs not idle after reset");
      for (int r = 0; r < 3; r++) begin
         run_reconfig(r);
      end
      // Lock has to come back once more after the last run
      wait_for_ready();
      if (done_cnt == 3) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         fail_run($sformatf("mismatch reconfig_runs expected 3 actual %0d", done_cnt));
      end
   end

endmodule
